// File: common/cbc_types_pkg.sv
package cbc_types_pkg;

  // --------------------
  // sizes
  // --------------------

  // parallel decrypt lanes
  localparam int N_LANES = 4;

  // stream words in one block
  localparam int WORDS_PER_BLOCK = 4;

  localparam int WORD_W = 32;
  localparam int BLOCK_W = WORDS_PER_BLOCK * WORD_W;

  // --------------------
  // data shapes
  // --------------------

  // one stream word
  typedef logic [WORD_W-1:0] word_t;

  // cipher block, key or iv
  typedef logic [BLOCK_W-1:0] block_t;

  // lane select
  typedef logic [$clog2(N_LANES)-1:0] lane_idx_t;

  // word position inside a block, 0 is the top word
  typedef logic [$clog2(WORDS_PER_BLOCK)-1:0] word_idx_t;

endpackage

// File: common/cbc_ctrl_pkg.sv
package cbc_ctrl_pkg;

  // stand-in cipher rounds, one per cycle
  localparam int DEC_ROUNDS = 10;

  typedef logic [3:0] round_cnt_t;

  // --------------------
  // fsm states
  // --------------------

  // dispatcher intake
  typedef enum logic [1:0] {
    KEY   = 2'd0,
    IV    = 2'd1,
    BLOCK = 2'd2
  } intake_state_e;

  // decrypt lane
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    DONE = 2'd2
  } lane_state_e;

endpackage

// File: cbc_core/cbc_dispatch.sv
`timescale 1ns/1ps

module cbc_dispatch (
  input  logic                                 clk,
  input  logic                                 reset_n,

  input  cbc_types_pkg::word_t                 key_data,
  input  logic                                 key_valid,
  output logic                                 key_ready,

  input  cbc_types_pkg::word_t                 ct_data,
  input  logic                                 ct_valid,
  input  logic                                 ct_last,
  output logic                                 ct_ready,

  input  logic [cbc_types_pkg::N_LANES-1:0]    lane_busy,
  output logic [cbc_types_pkg::N_LANES-1:0]    lane_load,
  output cbc_types_pkg::block_t                lane_key,
  output cbc_types_pkg::block_t                lane_block,
  output cbc_types_pkg::block_t                lane_chain,
  output logic                                 lane_last
);

  localparam int LOW_W = cbc_types_pkg::BLOCK_W - cbc_types_pkg::WORD_W;

  cbc_ctrl_pkg::intake_state_e state;
  cbc_types_pkg::word_idx_t    word_cnt;
  cbc_types_pkg::lane_idx_t    ptr;

  // held low through reset and the cycle after it
  logic armed;

  // block_sr holds a complete block or iv this cycle
  logic full_q;

  cbc_types_pkg::block_t key_reg;
  cbc_types_pkg::block_t block_sr;
  cbc_types_pkg::block_t chain_reg;
  logic                  last_reg;

  logic key_fire;
  logic ct_fire;
  logic word_end;

  // --------------------
  // stream handshakes
  // --------------------

  assign key_ready = armed && (state == cbc_ctrl_pkg::KEY);

  // stall blocks while the lane in turn still holds older work
  assign ct_ready = armed && ((state == cbc_ctrl_pkg::IV) ||
                    ((state == cbc_ctrl_pkg::BLOCK) && !lane_busy[ptr]));

  assign key_fire = key_valid && key_ready;
  assign ct_fire  = ct_valid && ct_ready;
  assign word_end = (word_cnt ==
                     cbc_types_pkg::word_idx_t'(cbc_types_pkg::WORDS_PER_BLOCK - 1));

  // --------------------
  // intake fsm
  // --------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      armed     <= 1'b0;
      state     <= cbc_ctrl_pkg::KEY;
      word_cnt  <= '0;
      ptr       <= '0;
      full_q    <= 1'b0;
      lane_load <= '0;
    end else begin
      armed     <= 1'b1;
      full_q    <= 1'b0;
      lane_load <= '0;

      if (key_fire || ct_fire) begin
        word_cnt <= word_end ? '0 : word_cnt + 1'b1;
      end

      case (state)
        cbc_ctrl_pkg::KEY: begin
          if (key_fire && word_end) begin
            state <= cbc_ctrl_pkg::IV;
          end
        end
        cbc_ctrl_pkg::IV: begin
          if (ct_fire && word_end) begin
            full_q <= 1'b1;
            state  <= cbc_ctrl_pkg::BLOCK;
          end
        end
        cbc_ctrl_pkg::BLOCK: begin
          if (ct_fire && word_end) begin
            full_q         <= 1'b1;
            lane_load[ptr] <= 1'b1;
            if (ct_last) begin
              // same key, next message starts with its iv
              ptr   <= '0;
              state <= cbc_ctrl_pkg::IV;
            end else if (ptr == cbc_types_pkg::lane_idx_t'(cbc_types_pkg::N_LANES - 1)) begin
              ptr <= '0;
            end else begin
              ptr <= ptr + 1'b1;
            end
          end
        end
        default: begin
          state <= cbc_ctrl_pkg::KEY;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  always_ff @(posedge clk) begin
    // first word ends up in the top bits
    if (key_fire) begin
      key_reg <= {key_reg[LOW_W-1:0], key_data};
    end
    if (ct_fire) begin
      block_sr <= {block_sr[LOW_W-1:0], ct_data};
    end
    if (ct_fire && word_end) begin
      last_reg <= ct_last;
    end
    // lane captures the old chain on the same edge
    if (full_q) begin
      chain_reg <= block_sr;
    end
  end

  assign lane_key   = key_reg;
  assign lane_block = block_sr;
  assign lane_chain = chain_reg;
  assign lane_last  = last_reg;

endmodule

// File: cbc_core/cbc_lane.sv
`timescale 1ns/1ps

module cbc_lane (
  input  logic                   clk,
  input  logic                   reset_n,

  input  logic                   load,
  input  logic                   take,
  input  cbc_types_pkg::block_t  key,
  input  cbc_types_pkg::block_t  block,
  input  cbc_types_pkg::block_t  chain,
  input  logic                   last,

  output logic                   busy,
  output logic                   done,
  output cbc_types_pkg::block_t  result,
  output logic                   result_last
);

  localparam int BW = cbc_types_pkg::BLOCK_W;

  cbc_ctrl_pkg::lane_state_e state;
  cbc_ctrl_pkg::round_cnt_t  round_cnt;

  cbc_types_pkg::block_t data_q;
  cbc_types_pkg::block_t chain_q;
  logic                  last_q;

  logic last_round;

  assign last_round = (round_cnt == cbc_ctrl_pkg::round_cnt_t'(cbc_ctrl_pkg::DEC_ROUNDS - 1));

  // --------------------
  // lane fsm
  // --------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= cbc_ctrl_pkg::IDLE;
      round_cnt <= '0;
    end else begin
      case (state)
        cbc_ctrl_pkg::IDLE: begin
          if (load) begin
            round_cnt <= '0;
            state     <= cbc_ctrl_pkg::RUN;
          end
        end
        cbc_ctrl_pkg::RUN: begin
          round_cnt <= round_cnt + 1'b1;
          if (last_round) begin
            state <= cbc_ctrl_pkg::DONE;
          end
        end
        cbc_ctrl_pkg::DONE: begin
          if (take) begin
            state <= cbc_ctrl_pkg::IDLE;
          end
        end
        default: begin
          state <= cbc_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  // --------------------
  // rounds
  // --------------------

  always_ff @(posedge clk) begin
    if (load && (state == cbc_ctrl_pkg::IDLE)) begin
      data_q  <= block;
      chain_q <= chain;
      last_q  <= last;
    end else if (state == cbc_ctrl_pkg::RUN) begin
      // rotate left one byte, then key
      data_q <= {data_q[BW-9:0], data_q[BW-1:BW-8]} ^ key;
    end
  end

  assign busy        = (state != cbc_ctrl_pkg::IDLE);
  assign done        = (state == cbc_ctrl_pkg::DONE);
  assign result      = data_q ^ chain_q;
  assign result_last = last_q;

endmodule

// File: cbc_core/cbc_collect.sv
`timescale 1ns/1ps

module cbc_collect (
  input  logic                                              clk,
  input  logic                                              reset_n,

  input  logic [cbc_types_pkg::N_LANES-1:0]                 lane_done,
  input  cbc_types_pkg::block_t [cbc_types_pkg::N_LANES-1:0] lane_result,
  input  logic [cbc_types_pkg::N_LANES-1:0]                 lane_result_last,
  output logic [cbc_types_pkg::N_LANES-1:0]                 lane_take,

  output cbc_types_pkg::word_t                              pt_data,
  output logic                                              pt_valid,
  output logic                                              pt_last,
  input  logic                                              pt_ready
);

  localparam int WPB = cbc_types_pkg::WORDS_PER_BLOCK;
  localparam int WW  = cbc_types_pkg::WORD_W;

  cbc_types_pkg::lane_idx_t ptr;
  cbc_types_pkg::word_idx_t widx;

  cbc_types_pkg::word_t int_data;
  logic                 int_last;
  logic                 int_ready_q;
  logic                 int_ready_early;
  logic                 emit;
  logic                 blk_end;

  logic                 out_valid_q;
  logic                 out_valid_next;
  logic                 out_last_q;
  cbc_types_pkg::word_t out_data_q;

  logic                 tmp_valid_q;
  logic                 tmp_valid_next;
  logic                 tmp_last_q;
  cbc_types_pkg::word_t tmp_data_q;

  logic store_int_to_out;
  logic store_int_to_tmp;
  logic store_tmp_to_out;

  // --------------------
  // lane drain
  // --------------------

  assign blk_end  = (widx == cbc_types_pkg::word_idx_t'(WPB - 1));
  assign int_data = lane_result[ptr][WW * (WPB - 1 - widx) +: WW];
  assign int_last = blk_end && lane_result_last[ptr];

  // ready is registered, so the sink never reaches the lane mux
  assign emit = lane_done[ptr] && int_ready_q;

  always_comb begin
    lane_take = '0;
    if (emit && blk_end) begin
      lane_take[ptr] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ptr  <= '0;
      widx <= '0;
    end else if (emit) begin
      widx <= widx + 1'b1;
      if (blk_end) begin
        widx <= '0;
        if (lane_result_last[ptr] ||
            (ptr == cbc_types_pkg::lane_idx_t'(cbc_types_pkg::N_LANES - 1))) begin
          ptr <= '0;
        end else begin
          ptr <= ptr + 1'b1;
        end
      end
    end
  end

  // --------------------
  // skid buffer
  // --------------------

  assign int_ready_early = pt_ready || (!tmp_valid_q && (!out_valid_q || !emit));

  always_comb begin
    out_valid_next   = out_valid_q;
    tmp_valid_next   = tmp_valid_q;
    store_int_to_out = 1'b0;
    store_int_to_tmp = 1'b0;
    store_tmp_to_out = 1'b0;

    if (int_ready_q) begin
      if (pt_ready || !out_valid_q) begin
        out_valid_next   = emit;
        store_int_to_out = 1'b1;
      end else begin
        tmp_valid_next   = emit;
        store_int_to_tmp = 1'b1;
      end
    end else if (pt_ready) begin
      // drain the stalled word first
      out_valid_next   = tmp_valid_q;
      tmp_valid_next   = 1'b0;
      store_tmp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      out_valid_q <= 1'b0;
      tmp_valid_q <= 1'b0;
      int_ready_q <= 1'b0;
    end else begin
      out_valid_q <= out_valid_next;
      tmp_valid_q <= tmp_valid_next;
      int_ready_q <= int_ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (store_int_to_out) begin
      out_data_q <= int_data;
      out_last_q <= int_last;
    end else if (store_tmp_to_out) begin
      out_data_q <= tmp_data_q;
      out_last_q <= tmp_last_q;
    end
    if (store_int_to_tmp) begin
      tmp_data_q <= int_data;
      tmp_last_q <= int_last;
    end
  end

  assign pt_data  = out_data_q;
  assign pt_valid = out_valid_q;
  assign pt_last  = out_last_q;

endmodule

// File: logic/cbc_decrypt_top.sv
`timescale 1ns/1ps

module cbc_decrypt_top (
  input  logic                  clk,
  input  logic                  reset_n,

  input  cbc_types_pkg::word_t  key_data,
  input  logic                  key_valid,
  output logic                  key_ready,

  input  cbc_types_pkg::word_t  ct_data,
  input  logic                  ct_valid,
  input  logic                  ct_last,
  output logic                  ct_ready,

  output cbc_types_pkg::word_t  pt_data,
  output logic                  pt_valid,
  output logic                  pt_last,
  input  logic                  pt_ready
);

  localparam int NL = cbc_types_pkg::N_LANES;

  // dispatcher to lanes
  logic [NL-1:0]         lane_load;
  logic [NL-1:0]         lane_busy;
  cbc_types_pkg::block_t lane_key;
  cbc_types_pkg::block_t lane_block;
  cbc_types_pkg::block_t lane_chain;
  logic                  lane_last;

  // lanes to collector
  logic [NL-1:0]                  lane_done;
  logic [NL-1:0]                  lane_take;
  logic [NL-1:0]                  lane_result_last;
  cbc_types_pkg::block_t [NL-1:0] lane_result;

  cbc_dispatch u_dispatch (
    .clk        (clk),
    .reset_n    (reset_n),
    .key_data   (key_data),
    .key_valid  (key_valid),
    .key_ready  (key_ready),
    .ct_data    (ct_data),
    .ct_valid   (ct_valid),
    .ct_last    (ct_last),
    .ct_ready   (ct_ready),
    .lane_busy  (lane_busy),
    .lane_load  (lane_load),
    .lane_key   (lane_key),
    .lane_block (lane_block),
    .lane_chain (lane_chain),
    .lane_last  (lane_last)
  );

  for (genvar i = 0; i < NL; i++) begin : g_lane
    cbc_lane u_lane (
      .clk         (clk),
      .reset_n     (reset_n),
      .load        (lane_load[i]),
      .take        (lane_take[i]),
      .key         (lane_key),
      .block       (lane_block),
      .chain       (lane_chain),
      .last        (lane_last),
      .busy        (lane_busy[i]),
      .done        (lane_done[i]),
      .result      (lane_result[i]),
      .result_last (lane_result_last[i])
    );
  end

  cbc_collect u_collect (
    .clk              (clk),
    .reset_n          (reset_n),
    .lane_done        (lane_done),
    .lane_result      (lane_result),
    .lane_result_last (lane_result_last),
    .lane_take        (lane_take),
    .pt_data          (pt_data),
    .pt_valid         (pt_valid),
    .pt_last          (pt_last),
    .pt_ready         (pt_ready)
  );

endmodule

// File: sim/tb_cbc_decrypt.sv
`timescale 1ns/1ps

module tb_cbc_decrypt;

  localparam int WW  = cbc_types_pkg::WORD_W;
  localparam int BW  = cbc_types_pkg::BLOCK_W;
  localparam int WPB = cbc_types_pkg::WORDS_PER_BLOCK;

  // key, then iv plus blocks of every message, in words
  localparam int TOTAL_WORDS     = 4 + 8 + 32 + 28 + 24 + 28;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 1000;

  logic                 clk;
  logic                 reset_n;
  cbc_types_pkg::word_t key_data;
  logic                 key_valid;
  logic                 key_ready;
  cbc_types_pkg::word_t ct_data;
  logic                 ct_valid;
  logic                 ct_last;
  logic                 ct_ready;
  cbc_types_pkg::word_t pt_data;
  logic                 pt_valid;
  logic                 pt_last;
  logic                 pt_ready;

  cbc_types_pkg::block_t key_value;
  cbc_types_pkg::word_t  exp_data[$];
  logic                  exp_last[$];
  cbc_types_pkg::word_t  got_data[$];
  logic                  got_last[$];

  // separate streams for stimulus and the sink
  logic [31:0]          stim_lcg  = 32'd39697;
  logic [31:0]          ready_lcg = 32'd39697;
  bit                   ready_gaps;
  bit                   stall_q;
  cbc_types_pkg::word_t stall_data;
  logic                 stall_last;
  int                   checks;
  int                   errors;

  cbc_decrypt_top DUT (
    .clk       (clk),
    .reset_n   (reset_n),
    .key_data  (key_data),
    .key_valid (key_valid),
    .key_ready (key_ready),
    .ct_data   (ct_data),
    .ct_valid  (ct_valid),
    .ct_last   (ct_last),
    .ct_ready  (ct_ready),
    .pt_data   (pt_data),
    .pt_valid  (pt_valid),
    .pt_last   (pt_last),
    .pt_ready  (pt_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  // --------------------
  // model and lcg
  // --------------------

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic cbc_types_pkg::block_t random_block();
    cbc_types_pkg::block_t b;
    for (int w = 0; w < WPB; w++) begin
      stim_lcg = lcg_step(stim_lcg);
      b = {b[BW-WW-1:0], stim_lcg};
    end
    return b;
  endfunction

  // inverse stand-in cipher, then xor with the previous ciphertext
  function automatic cbc_types_pkg::block_t cbc_plain(input cbc_types_pkg::block_t ct,
                                                      input cbc_types_pkg::block_t prev,
                                                      input cbc_types_pkg::block_t key);
    cbc_types_pkg::block_t s;
    s = ct;
    for (int r = 0; r < cbc_ctrl_pkg::DEC_ROUNDS; r++) begin
      s = ((s << 8) | (s >> (BW - 8))) ^ key;
    end
    return s ^ prev;
  endfunction

  // --------------------
  // output monitor
  // --------------------

  always @(posedge clk) begin
    if (reset_n) begin
      if (stall_q) begin
        checks++;
        if (!pt_valid) begin
          errors++;
          $display("pt_valid dropped at %0t before the stalled word was taken", $time);
        end else if (pt_data !== stall_data) begin
          errors++;
          $display("mismatch at %0t: pt_data while stalled expected %h got %h",
                   $time, stall_data, pt_data);
        end else if (pt_last !== stall_last) begin
          errors++;
          $display("mismatch at %0t: pt_last while stalled expected %b got %b",
                   $time, stall_last, pt_last);
        end
      end
      if (pt_valid && pt_ready) begin
        got_data.push_back(pt_data);
        got_last.push_back(pt_last);
      end
      stall_q    = pt_valid && !pt_ready;
      stall_data = pt_data;
      stall_last = pt_last;
    end
  end

  always @(posedge clk) begin
    if (ready_gaps) begin
      ready_lcg = lcg_step(ready_lcg);
      pt_ready <= ready_lcg[31];
    end else begin
      pt_ready <= 1'b1;
    end
  end

  // --------------------
  // drivers
  // --------------------

  task automatic load_key(input cbc_types_pkg::block_t key);
    for (int w = 0; w < WPB; w++) begin
      key_data  <= key[BW-1-WW*w -: WW];
      key_valid <= 1'b1;
      @(posedge clk);
      while (!key_ready) @(posedge clk);
    end
    key_valid <= 1'b0;
  endtask

  task automatic send_word(input cbc_types_pkg::word_t data, input logic last, input bit gaps);
    int idle;
    idle = 0;
    if (gaps) begin
      stim_lcg = lcg_step(stim_lcg);
      idle     = int'(stim_lcg >> 30);
    end
    if (idle > 0) begin
      ct_valid <= 1'b0;
      repeat (idle) @(posedge clk);
    end
    ct_data  <= data;
    ct_last  <= last;
    ct_valid <= 1'b1;
    @(posedge clk);
    while (!ct_ready) @(posedge clk);
  endtask

  task automatic send_message(input int n_blocks, input bit gaps);
    cbc_types_pkg::block_t iv;
    cbc_types_pkg::block_t ct;
    cbc_types_pkg::block_t prev;
    cbc_types_pkg::block_t pt;
    iv   = random_block();
    prev = iv;
    for (int w = 0; w < WPB; w++) begin
      send_word(iv[BW-1-WW*w -: WW], 1'b0, gaps);
    end
    for (int b = 0; b < n_blocks; b++) begin
      ct = random_block();
      pt = cbc_plain(ct, prev, key_value);
      for (int w = 0; w < WPB; w++) begin
        exp_data.push_back(pt[BW-1-WW*w -: WW]);
        exp_last.push_back((b == n_blocks - 1) && (w == WPB - 1));
      end
      for (int w = 0; w < WPB; w++) begin
        send_word(ct[BW-1-WW*w -: WW], (b == n_blocks - 1) && (w == WPB - 1), gaps);
      end
      prev = ct;
    end
    ct_valid <= 1'b0;
    ct_last  <= 1'b0;
  endtask

  // handshake outputs held low
  task automatic quiet_outputs(input string phase);
    checks++;
    if (key_ready !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: key_ready %s expected 0 got %b", $time, phase, key_ready);
    end
    if (ct_ready !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: ct_ready %s expected 0 got %b", $time, phase, ct_ready);
    end
    if (pt_valid !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: pt_valid %s expected 0 got %b", $time, phase, pt_valid);
    end
  endtask

  // key is taken once per reset
  task automatic key_port_closed();
    @(posedge clk);
    checks++;
    if (key_ready !== 1'b0) begin
      errors++;
      $display("mismatch at %0t: key_ready after key load expected 0 got %b",
               $time, key_ready);
    end
  endtask

  // waits for all expected words, then compares them in order
  task automatic check_output(input string name, input int n_last);
    int waited;
    int lasts;
    waited = 0;
    lasts  = 0;
    while (got_data.size() < exp_data.size() && waited < exp_data.size() * 40 + 200) begin
      @(posedge clk);
      waited++;
    end
    repeat (20) @(posedge clk);
    checks++;
    if (got_data.size() != exp_data.size()) begin
      errors++;
      $display("%s: expected %0d plaintext words but received %0d",
               name, exp_data.size(), got_data.size());
    end
    for (int i = 0; i < exp_data.size() && i < got_data.size(); i++) begin
      checks++;
      if (got_data[i] !== exp_data[i]) begin
        errors++;
        $display("mismatch at %0t: pt_data word %0d expected %h got %h",
                 $time, i, exp_data[i], got_data[i]);
      end
      if (got_last[i] !== exp_last[i]) begin
        errors++;
        $display("mismatch at %0t: pt_last word %0d expected %b got %b",
                 $time, i, exp_last[i], got_last[i]);
      end
      if (got_last[i] === 1'b1) begin
        lasts++;
      end
    end
    checks++;
    if (lasts != n_last) begin
      errors++;
      $display("%s: expected %0d words with pt_last but saw %0d", name, n_last, lasts);
    end
    exp_data.delete();
    exp_last.delete();
    got_data.delete();
    got_last.delete();
  endtask

  // --------------------
  // tests
  // --------------------

  task automatic single_block();
    send_message(1, 1'b0);
    check_output("single block", 1);
  endtask

  task automatic wrap_all_lanes();
    send_message(7, 1'b0);
    check_output("lane wrap", 1);
  endtask

  task automatic output_backpressure();
    ready_gaps <= 1'b1;
    send_message(6, 1'b0);
    check_output("output back-pressure", 1);
    ready_gaps <= 1'b0;
  endtask

  task automatic input_gaps();
    send_message(5, 1'b1);
    check_output("input gaps", 1);
  endtask

  task automatic back_to_back();
    send_message(3, 1'b0);
    send_message(2, 1'b0);
    check_output("back-to-back messages", 2);
  endtask

  initial begin
    reset_n    = 1'b0;
    key_data   = '0;
    key_valid  = 1'b0;
    ct_data    = '0;
    ct_valid   = 1'b0;
    ct_last    = 1'b0;
    pt_ready   = 1'b0;
    ready_gaps = 1'b0;
    stall_q    = 1'b0;
    repeat (8) @(posedge clk);
    quiet_outputs("in reset");
    reset_n <= 1'b1;
    @(posedge clk);
    quiet_outputs("after reset");

    key_value = random_block();
    load_key(key_value);
    key_port_closed();
    single_block();
    wrap_all_lanes();
    output_backpressure();
    input_gaps();
    back_to_back();

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
common/cbc_types_pkg.sv
common/cbc_ctrl_pkg.sv
cbc_core/cbc_dispatch.sv
cbc_core/cbc_lane.sv
cbc_core/cbc_collect.sv
logic/cbc_decrypt_top.sv
sim/tb_cbc_decrypt.sv

// File: Bender.yml
package:
  name: cbc_decrypt

sources:
  - common/cbc_types_pkg.sv
  - common/cbc_ctrl_pkg.sv
  - cbc_core/cbc_dispatch.sv
  - cbc_core/cbc_lane.sv
  - cbc_core/cbc_collect.sv
  - logic/cbc_decrypt_top.sv
  - target: simulation
    files:
      - sim/tb_cbc_decrypt.sv
